//--- Bender.yml
package:
  name: e100

sources:
  - src/e100_isa_pkg.sv
  - src/e100_ctrl_pkg.sv
  - src/e100_ctrl_if.sv
  - src/e100_mem_if.sv
  - src/e100_control.sv
  - src/e100_datapath.sv
  - src/e100_apb_master.sv
  - src/e100_cpu.sv
  - target: test
    files:
      - bench/e100_tb_mem.sv
      - bench/e100_tb.sv

//--- all.f
src/e100_isa_pkg.sv
src/e100_ctrl_pkg.sv
src/e100_ctrl_if.sv
src/e100_mem_if.sv
src/e100_control.sv
src/e100_datapath.sv
src/e100_apb_master.sv
src/e100_cpu.sv
bench/e100_tb_mem.sv
bench/e100_tb.sv

//--- bench/e100_tb.sv
/*
 * testbench for the e100 core
 * program images, reference interpreter, write log comparison and watchdog
 */
`timescale 1ns/1ps

module e100_tb;
    import e100_isa_pkg::*;

    localparam int addr_width = 10;
    localparam int mem_words = 1 << addr_width;
    localparam int num_tests = 7;
    localparam int max_instr = 400;
    localparam int timeout_ns = num_tests * max_instr * 40 * 40;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  waits_on;
    logic [word_width-1:0] prdata;
    logic                  pready;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [word_width-1:0] pwdata;
    logic                  halted;

    logic [word_width-1:0] image [0:mem_words-1];
    logic [word_width-1:0] ref_mem [0:mem_words-1];
    logic [addr_width-1:0] exp_addr [0:mem_words-1];
    logic [word_width-1:0] exp_data [0:mem_words-1];
    int                    exp_count;
    int                    prog_pc;
    logic [word_width-1:0] rand_a;
    logic [word_width-1:0] rand_b;
    string                 current_test;
    int                    test_index;
    int                    test_errors;
    int                    error_count;
    int                    failed_tests;
    bit                    check_go;

    always #20 clock = ~clock;

    e100_cpu #(
        .addr_width(addr_width)
    ) i_dut (
        .clock   (clock),
        .reset   (reset),
        .prdata  (prdata),
        .pready  (pready),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .halted  (halted)
    );

    e100_tb_mem #(
        .addr_width(addr_width)
    ) i_mem (
        .clock    (clock),
        .reset    (reset),
        .waits_on (waits_on),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

    task automatic report_mismatch(input string name, input logic [word_width-1:0] got,
                                   input logic [word_width-1:0] expected);
        $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, expected);
        test_errors++;
    endtask

    function automatic void record_write(input logic [addr_width-1:0] dst,
                                         input logic [word_width-1:0] value);
        ref_mem[dst] = value;
        exp_addr[exp_count] = dst;
        exp_data[exp_count] = value;
        exp_count++;
    endfunction

    // interprets the image and returns 1 once the program halts
    function automatic bit run_reference();
        logic [addr_width-1:0] pc;
        logic [addr_width-1:0] dst;
        logic [word_width-1:0] opc;
        logic [word_width-1:0] a1;
        logic [word_width-1:0] a2;
        logic [word_width-1:0] a3;
        logic [word_width-1:0] x;
        logic [word_width-1:0] y;
        logic [word_width-1:0] idx;
        int a;
        int steps;
        pc = '0;
        exp_count = 0;
        for (a = 0; a < mem_words; a++) begin
            ref_mem[a] = image[a];
        end
        for (steps = 0; steps < max_instr; steps++) begin
            opc = ref_mem[pc];
            pc = pc + 1;
            a1 = ref_mem[pc];
            pc = pc + 1;
            a2 = ref_mem[pc];
            pc = pc + 1;
            a3 = ref_mem[pc];
            pc = pc + 1;
            dst = a1[addr_width-1:0];
            x = ref_mem[a2[addr_width-1:0]];
            y = ref_mem[a3[addr_width-1:0]];
            case (opc)
                op_add: record_write(dst, x + y);
                op_sub: record_write(dst, x - y);
                op_and: record_write(dst, x & y);
                op_or: record_write(dst, x | y);
                op_not: record_write(dst, ~x);
                op_cp: record_write(dst, x);
                op_cpfa: begin
                    idx = a2 + y;
                    record_write(dst, ref_mem[idx[addr_width-1:0]]);
                end
                op_be: begin
                    if (x == y) begin
                        pc = dst;
                    end
                end
                op_blt: begin
                    if ($signed(x) < $signed(y)) begin
                        pc = dst;
                    end
                end
                default: return 1'b1;
            endcase
        end
        return 1'b0;
    endfunction

    task automatic put_instr(input logic [word_width-1:0] opc, input logic [word_width-1:0] a1,
                             input logic [word_width-1:0] a2, input logic [word_width-1:0] a3);
        image[prog_pc] = opc;
        image[prog_pc + 1] = a1;
        image[prog_pc + 2] = a2;
        image[prog_pc + 3] = a3;
        prog_pc += 4;
    endtask

    task automatic build_program(input int which);
        int a;
        for (a = 0; a < mem_words; a++) begin
            image[a] = 32'h5a5a0000 ^ (a * 32'h9e3779b1);
        end
        prog_pc = 0;
        case (which)
            0: begin
                image[600] = 32'h7fffffff;
                image[601] = 32'd1;
                image[602] = rand_a;
                image[603] = rand_b;
                image[604] = 32'hffff0000;
                // signed overflow on the first add
                put_instr(op_add, 700, 600, 601);
                put_instr(op_sub, 701, 602, 603);
                put_instr(op_and, 702, 602, 604);
                put_instr(op_or, 703, 603, 604);
                put_instr(op_not, 704, 602, 0);
                put_instr(op_add, 705, 700, 702);
                put_instr(op_sub, 706, 601, 600);
                put_instr(op_halt, 0, 0, 0);
            end
            1: begin
                image[600] = 32'h12345678;
                image[605] = 32'd3;
                image[606] = 32'd0;
                // index of -2 reaches below the table base
                image[607] = 32'hfffffffe;
                image[608] = 32'h0bad0608;
                for (a = 0; a < 8; a++) begin
                    image[610 + a] = 32'hc0de0000 + a * 17;
                end
                put_instr(op_cp, 700, 600, 0);
                put_instr(op_cpfa, 701, 610, 605);
                put_instr(op_cpfa, 702, 610, 606);
                put_instr(op_cpfa, 703, 610, 607);
                put_instr(op_cp, 704, 701, 0);
                put_instr(op_halt, 0, 0, 0);
            end
            2: begin
                image[600] = 32'd42;
                image[601] = 32'd42;
                image[602] = 32'd43;
                image[603] = 32'hfffffffb;
                image[604] = 32'd3;
                image[605] = 32'hfffffff9;
                image[606] = 32'hfffffffe;
                image[607] = 32'h11111111;
                // each taken branch skips the copy right after it
                put_instr(op_be, prog_pc + 8, 600, 601);
                put_instr(op_cp, 700, 607, 0);
                put_instr(op_be, prog_pc + 8, 600, 602);
                put_instr(op_cp, 701, 607, 0);
                put_instr(op_blt, prog_pc + 8, 603, 604);
                put_instr(op_cp, 702, 607, 0);
                put_instr(op_blt, prog_pc + 8, 604, 603);
                put_instr(op_cp, 703, 607, 0);
                put_instr(op_blt, prog_pc + 8, 605, 606);
                put_instr(op_cp, 704, 607, 0);
                put_instr(op_blt, prog_pc + 8, 600, 601);
                put_instr(op_cp, 705, 607, 0);
                put_instr(op_cp, 706, 600, 0);
                put_instr(op_halt, 0, 0, 0);
            end
            3: begin
                put_instr(op_halt, 1, 2, 3);
                put_instr(op_cp, 700, 600, 0);
            end
            default: begin
                image[600] = 32'd5;
                image[601] = 32'd6;
                put_instr(op_add, 700, 600, 601);
                // opcode 3 is the unsupported mult
                put_instr(32'd3, 701, 600, 601);
                put_instr(op_cp, 702, 600, 0);
            end
        endcase
    endtask

    task automatic load_and_reset(input bit waits);
        int a;
        @(posedge clock);
        reset <= 1'b1;
        waits_on <= waits;
        repeat (7) begin
            @(posedge clock);
            @(negedge clock);
            if (psel !== 1'b0) begin
                report_mismatch("psel", psel, 0);
            end
            if (penable !== 1'b0) begin
                report_mismatch("penable", penable, 0);
            end
            if (pwrite !== 1'b0) begin
                report_mismatch("pwrite", pwrite, 0);
            end
            if (halted !== 1'b0) begin
                report_mismatch("halted", halted, 0);
            end
        end
        for (a = 0; a < mem_words; a++) begin
            i_mem.words[a] = image[a];
        end
        @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic run_and_check();
        if (!run_reference()) begin
            $display("reference program did not halt within %0d instructions", max_instr);
            test_errors++;
        end
        while (halted !== 1'b1) begin
            @(negedge clock);
        end
        // the bus stays quiet once halted
        repeat (10) begin
            @(negedge clock);
            if (psel !== 1'b0) begin
                $display("psel went high after halt at %0t", $time);
                test_errors++;
            end
        end
        check_go = 1'b1;
        wait (check_go == 1'b0);
    endtask

    task automatic run_test(input string name, input int which, input bit waits,
                            input int early_reset);
        test_index++;
        current_test = name;
        test_errors = 0;
        build_program(which);
        load_and_reset(waits);
        if (early_reset > 0) begin
            repeat (early_reset) @(posedge clock);
            load_and_reset(waits);
        end
        run_and_check();
        if (test_errors == 0) begin
            $display("test %0d %s: ok", test_index, name);
        end else begin
            $display("test %0d %s: %0d errors", test_index, name, test_errors);
            failed_tests++;
        end
        error_count += test_errors;
    endtask

    initial begin : compare_results
        int i;
        int count;
        forever begin
            wait (check_go == 1'b1);
            count = i_mem.log_count;
            if (count != exp_count) begin
                report_mismatch("write count", count, exp_count);
            end
            for (i = 0; i < count && i < exp_count; i++) begin
                if (i_mem.log_addr[i] !== exp_addr[i]) begin
                    report_mismatch($sformatf("address of write %0d", i), i_mem.log_addr[i],
                                    exp_addr[i]);
                end
                if (i_mem.log_data[i] !== exp_data[i]) begin
                    report_mismatch($sformatf("data of write %0d", i), i_mem.log_data[i],
                                    exp_data[i]);
                end
            end
            for (i = 0; i < mem_words; i++) begin
                if (i_mem.words[i] !== ref_mem[i]) begin
                    report_mismatch($sformatf("mem[%0d]", i), i_mem.words[i], ref_mem[i]);
                end
            end
            check_go = 1'b0;
        end
    end

    initial begin : run_tests
        int unsigned seed;
        int a;
        reset = 1'b1;
        waits_on = 1'b0;
        check_go = 1'b0;
        error_count = 0;
        failed_tests = 0;
        test_index = 0;
        current_test = "startup";
        seed = 32'hc60a1160;
        void'($urandom(seed));
        rand_a = $urandom;
        rand_b = $urandom;
        for (a = 0; a < 64; a++) begin
            i_mem.wait_table[a] = $urandom % 4;
        end
        run_test("alu", 0, 1'b1, 0);
        run_test("copies", 1, 1'b1, 0);
        run_test("branches", 2, 1'b1, 0);
        run_test("halt opcode", 3, 1'b1, 0);
        run_test("unsupported opcode", 4, 1'b1, 0);
        run_test("alu without waits", 0, 1'b0, 0);
        run_test("reset rerun", 0, 1'b1, 60);
        $display("%0d tests, %0d passed, %0d failed, %0d errors", test_index,
                 test_index - failed_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout, test %0d (%s) never halted", test_index, current_test);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- bench/e100_tb_mem.sv
/*
 * APB slave memory for the e100 testbench
 * wait states from a preset random table, ordered log of completed writes
 */
`timescale 1ns/1ps

module e100_tb_mem #(
    parameter int addr_width = 10
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                waits_on,
    input  logic [addr_width-1:0]               paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [e100_isa_pkg::word_width-1:0] pwdata,
    output logic [e100_isa_pkg::word_width-1:0] prdata,
    output logic                                pready
);
    import e100_isa_pkg::*;

    localparam int depth = 1 << addr_width;
    localparam int table_size = 64;

    logic [word_width-1:0] words [0:depth-1];
    logic [addr_width-1:0] log_addr [0:depth-1];
    logic [word_width-1:0] log_data [0:depth-1];
    int                    log_count = 0;
    // filled by the testbench, 0 to 3 cycles each
    int                    wait_table [0:table_size-1];
    int                    wait_index = 0;
    int                    wait_left = 0;
    logic                  ready_q = 1'b0;
    logic [word_width-1:0] rdata_q = '0;

    assign pready = ready_q;
    assign prdata = rdata_q;

    always @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b0;
            log_count <= 0;
            wait_index <= 0;
            wait_left <= 0;
        end else if (psel && !penable) begin
            // setup cycle, read data held through the access phase
            rdata_q <= words[paddr];
            if (waits_on) begin
                wait_left <= wait_table[wait_index];
                ready_q <= (wait_table[wait_index] == 0);
                wait_index <= (wait_index + 1) % table_size;
            end else begin
                wait_left <= 0;
                ready_q <= 1'b1;
            end
        end else if (psel && penable) begin
            if (ready_q) begin
                if (pwrite) begin
                    words[paddr] <= pwdata;
                    log_addr[log_count] <= paddr;
                    log_data[log_count] <= pwdata;
                    log_count <= log_count + 1;
                end
                ready_q <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
                ready_q <= (wait_left == 1);
            end
        end
    end

endmodule

//--- src/e100_apb_master.sv
/*
 * APB master for the e100 core
 * one memory request becomes one setup and access transfer
 */
`timescale 1ns/1ps

module e100_apb_master #(
    parameter int addr_width = 10
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [e100_isa_pkg::word_width-1:0] prdata,
    input  logic                              pready,
    e100_mem_if.apb                           mem,
    output logic [addr_width-1:0]             paddr,
    output logic                              psel,
    output logic                              penable,
    output logic                              pwrite,
    output logic [e100_isa_pkg::word_width-1:0] pwdata
);
    localparam logic [1:0] apb_idle = 2'd0;
    localparam logic [1:0] apb_setup = 2'd1;
    localparam logic [1:0] apb_access = 2'd2;

    logic [1:0] state;
    logic       request;

    assign request = mem.mem_read || mem.mem_write;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= apb_idle;
            pwrite <= 1'b0;
        end else begin
            case (state)
                apb_idle: begin
                    if (request) begin
                        state <= apb_setup;
                        pwrite <= mem.mem_write;
                    end
                end
                apb_setup:
                    state <= apb_access;
                apb_access: begin
                    if (pready) begin
                        state <= apb_idle;
                    end
                end
                default:
                    state <= apb_idle;
            endcase
        end
    end

    // transfer payload held for the whole transfer
    always_ff @(posedge clock) begin
        if (state == apb_idle && request) begin
            paddr <= mem.address;
            pwdata <= mem.write_data;
        end
    end

    assign psel = (state != apb_idle);
    assign penable = (state == apb_access);
    assign mem.done = (state == apb_access) && pready;
    assign mem.read_data = prdata;

    enable_needs_select: assert property (@(posedge clock) disable iff (reset)
        penable |-> psel);

    stable_until_complete: assert property (@(posedge clock) disable iff (reset)
        psel && !(penable && pready) |=> $stable(paddr) && $stable(pwrite));

endmodule

//--- src/e100_control.sv
/*
 * e100 microsequencer
 * fetch, decode and execute steps, memory steps wait for completion
 */
`timescale 1ns/1ps

module e100_control (
    input  logic         clock,
    input  logic         reset,
    e100_ctrl_if.control ctrl,
    e100_mem_if.control  mem,
    output logic         halted
);
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;

    logic [state_width-1:0]   state;
    logic [state_width-1:0]   next_state;
    // result source for st_op6, picked at decode
    logic [bus_sel_width-1:0] alu_sel;
    logic                     branch_lt;
    logic                     step_done;
    logic                     taken;

    assign halted = (state == st_halt);

    // memory steps
    assign mem.mem_read = state inside {st_fetch2, st_fetch4, st_fetch6, st_fetch8,
                                        st_op2, st_op4, st_not2, st_cp2, st_cpfa2,
                                        st_cpfa5, st_br2, st_br4};
    assign mem.mem_write = state inside {st_op6, st_not4, st_cp4, st_cpfa7};

    // a memory step holds until the transfer completes
    assign step_done = !(mem.mem_read || mem.mem_write) || mem.done;
    assign taken = branch_lt ? ctrl.less : ctrl.equal;

    // read data is captured only in the completion cycle
    assign ctrl.opcode_write = mem.done && state == st_fetch2;
    assign ctrl.arg1_write = mem.done && state == st_fetch4;
    assign ctrl.arg2_write = mem.done && state == st_fetch6;
    assign ctrl.arg3_write = mem.done && state inside {st_fetch8, st_cp2, st_cpfa5};
    assign ctrl.op1_write = mem.done && state inside {st_op2, st_not2, st_cpfa2, st_br2};
    assign ctrl.op2_write = (mem.done && state inside {st_op4, st_br4}) || state == st_cpfa3;
    assign ctrl.iar_write = state inside {st_fetch3, st_fetch5, st_fetch7, st_decode, st_br6};
    assign ctrl.address_write = state inside {st_fetch1, st_fetch3, st_fetch5, st_fetch7,
                                              st_op1, st_op3, st_op5, st_not1, st_not3,
                                              st_cp1, st_cp3, st_cpfa1, st_cpfa4, st_cpfa6,
                                              st_br1, st_br3};

    // microcode bus source table
    always_comb begin
        case (state)
            st_fetch1:
                ctrl.bus_sel = bus_iar;
            st_fetch3, st_fetch5, st_fetch7, st_decode:
                ctrl.bus_sel = bus_plus1;
            st_fetch2, st_fetch4, st_fetch6, st_fetch8, st_op2, st_op4, st_not2,
            st_cp2, st_cpfa2, st_cpfa5, st_br2, st_br4:
                ctrl.bus_sel = bus_mem;
            st_op1, st_not1, st_cp1, st_cpfa3, st_br1:
                ctrl.bus_sel = bus_arg2;
            st_op3, st_cp4, st_cpfa1, st_cpfa7, st_br3:
                ctrl.bus_sel = bus_arg3;
            st_op5, st_not3, st_cp3, st_cpfa6, st_br6:
                ctrl.bus_sel = bus_arg1;
            st_op6:
                ctrl.bus_sel = alu_sel;
            st_not4:
                ctrl.bus_sel = bus_not;
            // table base plus index
            st_cpfa4:
                ctrl.bus_sel = bus_add;
            default:
                ctrl.bus_sel = bus_none;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            st_decode: begin
                case (ctrl.opcode)
                    op_add, op_sub, op_and, op_or:
                        next_state = st_op1;
                    op_not:
                        next_state = st_not1;
                    op_cp:
                        next_state = st_cp1;
                    op_cpfa:
                        next_state = st_cpfa1;
                    op_be, op_blt:
                        next_state = st_br1;
                    // halt and anything unsupported
                    default:
                        next_state = st_halt;
                endcase
            end
            st_halt:
                next_state = st_halt;
            st_op6, st_not4, st_cp4, st_cpfa7, st_br6: begin
                if (step_done) begin
                    next_state = st_fetch1;
                end
            end
            st_br5:
                next_state = taken ? st_br6 : st_fetch1;
            default: begin
                if (step_done) begin
                    next_state = state + 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_reset;
            alu_sel <= bus_add;
            branch_lt <= 1'b0;
        end else begin
            state <= next_state;
            if (state == st_decode) begin
                branch_lt <= (ctrl.opcode == op_blt);
                case (ctrl.opcode)
                    op_sub: alu_sel <= bus_sub;
                    op_and: alu_sel <= bus_and;
                    op_or: alu_sel <= bus_or;
                    default: alu_sel <= bus_add;
                endcase
            end
        end
    end

    read_write_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(mem.mem_read && mem.mem_write));

    // only reset leaves halt
    halt_is_sticky: assert property (@(posedge clock)
        halted && !reset |=> halted);

endmodule

//--- src/e100_cpu.sv
/*
 * e100 multicycle core top level
 * control, datapath and APB master behind plain APB ports
 */
`timescale 1ns/1ps

module e100_cpu #(
    parameter int addr_width = 10
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [e100_isa_pkg::word_width-1:0] prdata,
    input  logic                                pready,
    output logic [addr_width-1:0]               paddr,
    output logic                                psel,
    output logic                                penable,
    output logic                                pwrite,
    output logic [e100_isa_pkg::word_width-1:0] pwdata,
    output logic                                halted
);

    e100_ctrl_if ctrl_bus ();

    e100_mem_if #(
        .addr_width(addr_width)
    ) mem_bus ();

    e100_control i_control (
        .clock  (clock),
        .reset  (reset),
        .ctrl   (ctrl_bus.control),
        .mem    (mem_bus.control),
        .halted (halted)
    );

    e100_datapath #(
        .addr_width(addr_width)
    ) i_datapath (
        .clock (clock),
        .reset (reset),
        .ctrl  (ctrl_bus.datapath),
        .mem   (mem_bus.datapath)
    );

    e100_apb_master #(
        .addr_width(addr_width)
    ) i_apb_master (
        .clock   (clock),
        .reset   (reset),
        .prdata  (prdata),
        .pready  (pready),
        .mem     (mem_bus.apb),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata)
    );

endmodule

//--- src/e100_ctrl_if.sv
/*
 * control to datapath interface
 * bus select, register write enables, opcode and compare status
 */
`timescale 1ns/1ps

interface e100_ctrl_if;
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;

    logic [bus_sel_width-1:0] bus_sel;
    logic                     iar_write;
    logic                     opcode_write;
    logic                     arg1_write;
    logic                     arg2_write;
    logic                     arg3_write;
    logic                     op1_write;
    logic                     op2_write;
    logic                     address_write;

    // status back to the sequencer
    logic [word_width-1:0]    opcode;
    logic                     equal;
    logic                     less;

    modport control (
        output bus_sel, iar_write, opcode_write, arg1_write, arg2_write, arg3_write,
               op1_write, op2_write, address_write,
        input  opcode, equal, less
    );

    modport datapath (
        input  bus_sel, iar_write, opcode_write, arg1_write, arg2_write, arg3_write,
               op1_write, op2_write, address_write,
        output opcode, equal, less
    );

endinterface

//--- src/e100_ctrl_pkg.sv
/*
 * microsequencer encodings
 * state codes and internal bus source selects
 */
package e100_ctrl_pkg;

    localparam int state_width = 6;

    // steps of one sequence must stay consecutive, the sequencer counts through them
    localparam logic [state_width-1:0]
        st_reset  = 6'd0,
        st_fetch1 = 6'd1,
        st_fetch2 = 6'd2,
        st_fetch3 = 6'd3,
        st_fetch4 = 6'd4,
        st_fetch5 = 6'd5,
        st_fetch6 = 6'd6,
        st_fetch7 = 6'd7,
        st_fetch8 = 6'd8,
        st_decode = 6'd9,
        st_halt   = 6'd10,
        // add, sub, and, or
        st_op1    = 6'd11,
        st_op2    = 6'd12,
        st_op3    = 6'd13,
        st_op4    = 6'd14,
        st_op5    = 6'd15,
        st_op6    = 6'd16,
        st_not1   = 6'd17,
        st_not2   = 6'd18,
        st_not3   = 6'd19,
        st_not4   = 6'd20,
        st_cp1    = 6'd21,
        st_cp2    = 6'd22,
        st_cp3    = 6'd23,
        st_cp4    = 6'd24,
        st_cpfa1  = 6'd25,
        st_cpfa2  = 6'd26,
        st_cpfa3  = 6'd27,
        st_cpfa4  = 6'd28,
        st_cpfa5  = 6'd29,
        st_cpfa6  = 6'd30,
        st_cpfa7  = 6'd31,
        // be and blt
        st_br1    = 6'd32,
        st_br2    = 6'd33,
        st_br3    = 6'd34,
        st_br4    = 6'd35,
        st_br5    = 6'd36,
        st_br6    = 6'd37;

    localparam int bus_sel_width = 4;

    localparam logic [bus_sel_width-1:0]
        bus_none  = 4'd0,
        bus_iar   = 4'd1,
        bus_plus1 = 4'd2,
        bus_arg1  = 4'd3,
        bus_arg2  = 4'd4,
        bus_arg3  = 4'd5,
        bus_mem   = 4'd6,
        bus_add   = 4'd7,
        bus_sub   = 4'd8,
        bus_and   = 4'd9,
        bus_or    = 4'd10,
        bus_not   = 4'd11;

endpackage

//--- src/e100_datapath.sv
/*
 * e100 single bus datapath
 * registers, bus source multiplexer, alu and compare
 */
`timescale 1ns/1ps

module e100_datapath #(
    parameter int addr_width = 10
) (
    input  logic          clock,
    input  logic          reset,
    e100_ctrl_if.datapath ctrl,
    e100_mem_if.datapath  mem
);
    import e100_isa_pkg::*;
    import e100_ctrl_pkg::*;

    logic [addr_width-1:0] iar;
    logic [addr_width-1:0] iar_plus1;
    logic [addr_width-1:0] address;
    logic [word_width-1:0] opcode;
    logic [word_width-1:0] arg1;
    logic [word_width-1:0] arg2;
    logic [word_width-1:0] arg3;
    logic [word_width-1:0] op1;
    logic [word_width-1:0] op2;
    logic [word_width-1:0] bus;

    assign iar_plus1 = iar + 1'b1;

    always_comb begin
        case (ctrl.bus_sel)
            bus_iar:   bus = word_width'(iar);
            bus_plus1: bus = word_width'(iar_plus1);
            bus_arg1:  bus = arg1;
            bus_arg2:  bus = arg2;
            bus_arg3:  bus = arg3;
            bus_mem:   bus = mem.read_data;
            bus_add:   bus = op1 + op2;
            bus_sub:   bus = op1 - op2;
            bus_and:   bus = op1 & op2;
            bus_or:    bus = op1 | op2;
            bus_not:   bus = ~op1;
            default:   bus = '0;
        endcase
    end

    // program starts at word 0
    always_ff @(posedge clock) begin
        if (reset) begin
            iar <= '0;
        end else if (ctrl.iar_write) begin
            iar <= bus[addr_width-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.opcode_write) begin
            opcode <= bus;
        end
        if (ctrl.arg1_write) begin
            arg1 <= bus;
        end
        if (ctrl.arg2_write) begin
            arg2 <= bus;
        end
        if (ctrl.arg3_write) begin
            arg3 <= bus;
        end
        if (ctrl.op1_write) begin
            op1 <= bus;
        end
        if (ctrl.op2_write) begin
            op2 <= bus;
        end
        if (ctrl.address_write) begin
            address <= bus[addr_width-1:0];
        end
    end

    assign ctrl.opcode = opcode;
    assign ctrl.equal = (op1 == op2);
    // blt compares signed words
    assign ctrl.less = ($signed(op1) < $signed(op2));

    assign mem.address = address;
    assign mem.write_data = bus;

    no_write_from_idle_bus: assert property (@(posedge clock) disable iff (reset)
        ctrl.bus_sel == bus_none |-> !(ctrl.iar_write || ctrl.opcode_write ||
        ctrl.arg1_write || ctrl.arg2_write || ctrl.arg3_write || ctrl.op1_write ||
        ctrl.op2_write || ctrl.address_write));

endmodule

//--- src/e100_isa_pkg.sv
/*
 * instruction set of the e100 core
 * word width and opcode values of the supported instructions
 */
package e100_isa_pkg;

    // one data word, also one instruction field
    localparam int word_width = 32;

    // opcodes are whole words
    localparam logic [word_width-1:0] op_halt = 32'd0;
    localparam logic [word_width-1:0] op_add  = 32'd1;
    localparam logic [word_width-1:0] op_sub  = 32'd2;
    localparam logic [word_width-1:0] op_cp   = 32'd5;
    localparam logic [word_width-1:0] op_and  = 32'd6;
    localparam logic [word_width-1:0] op_or   = 32'd7;
    localparam logic [word_width-1:0] op_not  = 32'd8;
    localparam logic [word_width-1:0] op_cpfa = 32'd11;
    localparam logic [word_width-1:0] op_be   = 32'd13;
    localparam logic [word_width-1:0] op_blt  = 32'd15;

endpackage

//--- src/e100_mem_if.sv
/*
 * memory request interface
 * level requests from control, address and data from datapath, completion from APB
 */
`timescale 1ns/1ps

interface e100_mem_if #(
    parameter int addr_width = 10
);
    import e100_isa_pkg::*;

    // held high until done
    logic                  mem_read;
    logic                  mem_write;
    logic [addr_width-1:0] address;
    logic [word_width-1:0] write_data;
    logic [word_width-1:0] read_data;
    // one cycle pulse at transfer end
    logic                  done;

    modport control (
        output mem_read, mem_write,
        input  done
    );

    modport datapath (
        output address, write_data,
        input  read_data
    );

    modport apb (
        input  mem_read, mem_write, address, write_data,
        output read_data, done
    );

endinterface
